// File: verilog/mvm_pkg.sv
`default_nettype none

package mvm_pkg;

    ////////////////////////////////////////
    // Matrix and vector geometry
    ////////////////////////////////////////

    // Columns of the matrix
    localparam int MATRIX_WIDTH = 20;
    // Rows of the matrix, also the vector length
    localparam int MATRIX_HEIGHT = 5;
    localparam int VECTOR_CELL_WIDTH = 8;
    localparam int MATRIX_CELL_WIDTH = 8;
    localparam int RESULT_CELL_WIDTH = 12;

    // MAC lanes, one matrix row each per beat
    localparam int TILING_ROW = 2;
    // Multipliers in one lane, full matrix width
    localparam int TILING_COL = 20;

    localparam int PRODUCT_WIDTH = VECTOR_CELL_WIDTH + MATRIX_CELL_WIDTH;
    // Room for MATRIX_HEIGHT full scale products
    localparam int ACC_WIDTH = PRODUCT_WIDTH + $clog2(MATRIX_HEIGHT);
    // Fraction bits dropped from each sum
    localparam int RESULT_SHIFT = 4;
    // Row groups per job, rounded up
    localparam int N_BEATS = (MATRIX_HEIGHT + TILING_ROW - 1) / TILING_ROW;
    localparam int BEAT_CNT_WIDTH = (N_BEATS > 1) ? $clog2(N_BEATS + 1) : 1;

    // Flat port widths
    localparam int VECTOR_BITS = MATRIX_HEIGHT * VECTOR_CELL_WIDTH;
    localparam int ROW_BITS = MATRIX_WIDTH * MATRIX_CELL_WIDTH;
    localparam int MATRIX_BITS = MATRIX_HEIGHT * ROW_BITS;
    localparam int RESULT_BITS = MATRIX_WIDTH * RESULT_CELL_WIDTH;
    // Largest value a result cell can hold
    localparam int unsigned RESULT_MAX = (1 << RESULT_CELL_WIDTH) - 1;

    ////////////////////////////////////////
    // Cell and row types
    ////////////////////////////////////////

    typedef logic [VECTOR_CELL_WIDTH-1:0] vector_cell_t;
    typedef logic [MATRIX_CELL_WIDTH-1:0] matrix_cell_t;
    typedef logic [PRODUCT_WIDTH-1:0] product_t;
    typedef logic [ACC_WIDTH-1:0] acc_t;
    typedef logic [RESULT_CELL_WIDTH-1:0] result_cell_t;

    // Packed rows keep element 0 at the low end
    typedef matrix_cell_t [TILING_COL-1:0] matrix_row_t;
    typedef product_t [TILING_COL-1:0] product_row_t;
    typedef acc_t [MATRIX_WIDTH-1:0] acc_row_t;
    typedef result_cell_t [MATRIX_WIDTH-1:0] result_row_t;

    // Row sequencer FSM
    typedef enum logic {
        SEQ_IDLE,
        SEQ_ISSUE
    } seq_state_t;

endpackage

`default_nettype wire

// File: verilog/mvm_beat_if.sv
`timescale 1ns/100ps
`default_nettype none

// One row group per beat, sequencer to accumulator
interface mvm_beat_if
    import mvm_pkg::*;
();

    // Single cycle strobe, no back-pressure
    logic beat_valid;
    // Beat opens a job
    logic first;
    // Beat closes a job
    logic last;
    // One vector cell per lane, zero past the last row
    vector_cell_t [TILING_ROW-1:0] vec_cells;
    // One matrix row per lane
    matrix_row_t [TILING_ROW-1:0] rows;

    modport source (
        output beat_valid,
        output first,
        output last,
        output vec_cells,
        output rows
    );

    modport sink (
        input beat_valid,
        input first,
        input last,
        input vec_cells,
        input rows
    );

endinterface

`default_nettype wire

// File: verilog/mvm_row_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module mvm_row_sequencer
    import mvm_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  logic [VECTOR_BITS-1:0] vector,
    input  logic [MATRIX_BITS-1:0] matrix,
    mvm_beat_if.source             beat
);

    seq_state_t state;
    // Next row group to issue while in SEQ_ISSUE
    logic [BEAT_CNT_WIDTH-1:0] beat_cnt;
    // Row group presented on the next edge
    logic [BEAT_CNT_WIDTH-1:0] grp;
    logic take_start;
    logic issue;
    logic grp_last;

    // Operands held for the rest of the job
    vector_cell_t vec_q [MATRIX_HEIGHT];
    matrix_row_t mat_q [MATRIX_HEIGHT];
    // Ports on the start edge, held copy afterwards
    vector_cell_t src_vec [MATRIX_HEIGHT];
    matrix_row_t src_mat [MATRIX_HEIGHT];
    // Lane contents for the next beat
    vector_cell_t nxt_vec [TILING_ROW];
    matrix_row_t nxt_rows [TILING_ROW];

    // Starts only count when idle
    assign take_start = start && (state == SEQ_IDLE);
    assign issue = take_start || (state == SEQ_ISSUE);
    // First group goes out straight from the ports
    assign grp = (state == SEQ_IDLE) ? '0 : beat_cnt;
    assign grp_last = (grp == BEAT_CNT_WIDTH'(N_BEATS - 1));

    ////////////////////////////////////////
    // Operand source and row selection
    ////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < MATRIX_HEIGHT; i++) begin
            if (state == SEQ_IDLE) begin
                src_vec[i] = vector[i*VECTOR_CELL_WIDTH +: VECTOR_CELL_WIDTH];
                src_mat[i] = matrix[i*ROW_BITS +: ROW_BITS];
            end else begin
                src_vec[i] = vec_q[i];
                src_mat[i] = mat_q[i];
            end
        end
    end

    always_comb begin
        int row_idx;
        for (int l = 0; l < TILING_ROW; l++) begin
            row_idx = int'(grp) * TILING_ROW + l;
            if (row_idx < MATRIX_HEIGHT) begin
                nxt_vec[l] = src_vec[row_idx];
                nxt_rows[l] = src_mat[row_idx];
            end else begin
                // Past the last row, lane contributes nothing
                nxt_vec[l] = '0;
                nxt_rows[l] = '0;
            end
        end
    end

    // Capture on an accepted start only
    always_ff @(posedge clk) begin
        if (take_start) begin
            for (int i = 0; i < MATRIX_HEIGHT; i++) begin
                vec_q[i] <= src_vec[i];
                mat_q[i] <= src_mat[i];
            end
        end
    end

    ////////////////////////////////////////
    // FSM and beat registers
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= SEQ_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (take_start) begin
                        beat_cnt <= BEAT_CNT_WIDTH'(1);
                        // Single group jobs never leave idle
                        state <= grp_last ? SEQ_IDLE : SEQ_ISSUE;
                    end
                end
                SEQ_ISSUE: begin
                    beat_cnt <= beat_cnt + 1'b1;
                    // Idle again while the last beat is on the bus
                    if (grp_last) begin
                        state <= SEQ_IDLE;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            beat.beat_valid <= 1'b0;
            beat.first <= 1'b0;
            beat.last <= 1'b0;
        end else begin
            beat.beat_valid <= issue;
            beat.first <= take_start;
            beat.last <= issue && grp_last;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            for (int l = 0; l < TILING_ROW; l++) begin
                beat.vec_cells[l] <= nxt_vec[l];
                beat.rows[l] <= nxt_rows[l];
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/vector_mac.sv
`timescale 1ns/100ps
`default_nettype none

// One lane, a vector cell against a whole matrix row
module vector_mac
    import mvm_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  vector_cell_t vec_cell,
    input  matrix_row_t  row,
    output product_row_t products
);

    // Full width products, nothing dropped here
    product_row_t prod_d;

    always_comb begin
        for (int j = 0; j < TILING_COL; j++) begin
            prod_d[j] = product_t'(vec_cell) * product_t'(row[j]);
        end
    end

    // Pipeline stage, products one cycle after their beat
    always_ff @(posedge clk) begin
        if (reset) begin
            products <= '0;
        end else begin
            products <= prod_d;
        end
    end

endmodule

`default_nettype wire

// File: verilog/mvm_accumulator.sv
`timescale 1ns/100ps
`default_nettype none

module mvm_accumulator
    import mvm_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    mvm_beat_if.sink beat,
    output logic     sums_valid,
    output acc_row_t sums
);

    product_row_t lane_products [TILING_ROW];
    // Per column sum over the lanes of one beat
    acc_row_t lane_sum;
    // Partial sums of the running job
    acc_row_t bank;
    // Beat strobes lined up with the products
    logic prod_valid;
    logic prod_first;
    logic prod_last;

    ////////////////////////////////////////
    // MAC lanes
    ////////////////////////////////////////

    for (genvar l = 0; l < TILING_ROW; l++) begin : g_lane
        vector_mac mac_i (
            .clk      (clk),
            .reset    (reset),
            .vec_cell (beat.vec_cells[l]),
            .row      (beat.rows[l]),
            .products (lane_products[l])
        );
    end

    // Matches the one cycle lane latency
    always_ff @(posedge clk) begin
        if (reset) begin
            prod_valid <= 1'b0;
            prod_first <= 1'b0;
            prod_last <= 1'b0;
        end else begin
            prod_valid <= beat.beat_valid;
            prod_first <= beat.beat_valid && beat.first;
            prod_last <= beat.beat_valid && beat.last;
        end
    end

    ////////////////////////////////////////
    // Column adders and partial-sum bank
    ////////////////////////////////////////

    // Column j of the lanes is matrix column j
    always_comb begin
        for (int j = 0; j < MATRIX_WIDTH; j++) begin
            lane_sum[j] = '0;
            for (int l = 0; l < TILING_ROW; l++) begin
                lane_sum[j] = lane_sum[j] + acc_t'(lane_products[l][j]);
            end
        end
    end

    // Load on first, so no clear cycle between jobs
    always_ff @(posedge clk) begin
        if (prod_valid) begin
            for (int j = 0; j < MATRIX_WIDTH; j++) begin
                bank[j] <= prod_first ? lane_sum[j] : bank[j] + lane_sum[j];
            end
        end
    end

    // Bank is final on the edge that ends the last product cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            sums_valid <= 1'b0;
        end else begin
            sums_valid <= prod_valid && prod_last;
        end
    end

    assign sums = bank;

endmodule

`default_nettype wire

// File: verilog/mvm_result_formatter.sv
`timescale 1ns/100ps
`default_nettype none

module mvm_result_formatter
    import mvm_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   sums_valid,
    input  acc_row_t               sums,
    output logic [RESULT_BITS-1:0] result,
    output logic                   valid,
    output logic                   error
);

    // Sums with the fraction bits gone
    acc_t shifted [MATRIX_WIDTH];
    // Clamped cells, column 0 at the low end
    result_row_t cells;
    // One flag per column that hit the ceiling
    logic [MATRIX_WIDTH-1:0] clamped;

    ////////////////////////////////////////
    // Shift and saturate
    ////////////////////////////////////////

    always_comb begin
        for (int j = 0; j < MATRIX_WIDTH; j++) begin
            shifted[j] = sums[j] >> RESULT_SHIFT;
            if (shifted[j] > acc_t'(RESULT_MAX)) begin
                clamped[j] = 1'b1;
                cells[j] = result_cell_t'(RESULT_MAX);
            end else begin
                clamped[j] = 1'b0;
                cells[j] = shifted[j][RESULT_CELL_WIDTH-1:0];
            end
        end
    end

    // Result and error hold until the next job lands
    always_ff @(posedge clk) begin
        if (reset) begin
            result <= '0;
            error <= 1'b0;
        end else if (sums_valid) begin
            result <= cells;
            error <= |clamped;
        end
    end

    // Single cycle strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else begin
            valid <= sums_valid;
        end
    end

endmodule

`default_nettype wire

// File: verilog/mvm.sv
`timescale 1ns/100ps
`default_nettype none

module mvm
    import mvm_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    // Cell 0 in the low bits
    input  logic [VECTOR_BITS-1:0] vector,
    // Row major, cell (0,0) in the low bits
    input  logic [MATRIX_BITS-1:0] matrix,
    // Column 0 in the low bits
    output logic [RESULT_BITS-1:0] result,
    output logic                   valid,
    output logic                   error
);

    ////////////////////////////////////////
    // Internal nets
    ////////////////////////////////////////

    // Row group beats
    mvm_beat_if beat_bus ();

    // Accumulator to formatter
    logic sums_valid;
    acc_row_t sums;

    ////////////////////////////////////////
    // Pipeline
    ////////////////////////////////////////

    // Captures operands and walks the row groups
    mvm_row_sequencer seq_i (
        .clk    (clk),
        .reset  (reset),
        .start  (start),
        .vector (vector),
        .matrix (matrix),
        .beat   (beat_bus.source)
    );

    // MAC lanes and column partial sums
    mvm_accumulator acc_i (
        .clk        (clk),
        .reset      (reset),
        .beat       (beat_bus.sink),
        .sums_valid (sums_valid),
        .sums       (sums)
    );

    // Fixed point scaling and saturation
    mvm_result_formatter fmt_i (
        .clk        (clk),
        .reset      (reset),
        .sums_valid (sums_valid),
        .sums       (sums),
        .result     (result),
        .valid      (valid),
        .error      (error)
    );

endmodule

`default_nettype wire

// File: dv/mvm_model.svh
`ifndef MVM_MODEL_SVH
`define MVM_MODEL_SVH

// Operands as plain cells, row index first
typedef int unsigned vec_arr_t [MATRIX_HEIGHT];
typedef int unsigned mat_arr_t [MATRIX_HEIGHT][MATRIX_WIDTH];

// Cell 0 lands in the low bits
function automatic logic [VECTOR_BITS-1:0] pack_vector(input vec_arr_t v);
    logic [VECTOR_BITS-1:0] flat;
    flat = '0;
    for (int i = 0; i < MATRIX_HEIGHT; i++) begin
        flat[i*VECTOR_CELL_WIDTH +: VECTOR_CELL_WIDTH] = v[i][VECTOR_CELL_WIDTH-1:0];
    end
    return flat;
endfunction

// Row major, cell (0,0) in the low bits
function automatic logic [MATRIX_BITS-1:0] pack_matrix(input mat_arr_t m);
    logic [MATRIX_BITS-1:0] flat;
    int pos;
    flat = '0;
    for (int i = 0; i < MATRIX_HEIGHT; i++) begin
        for (int j = 0; j < MATRIX_WIDTH; j++) begin
            pos = (i * MATRIX_WIDTH + j) * MATRIX_CELL_WIDTH;
            flat[pos +: MATRIX_CELL_WIDTH] = m[i][j][MATRIX_CELL_WIDTH-1:0];
        end
    end
    return flat;
endfunction

// Column j is the dot product of the vector with matrix column j,
// scaled down by the fraction bits and clamped to the cell ceiling
function automatic void expected_result(input vec_arr_t v, input mat_arr_t m,
                                        output logic [RESULT_BITS-1:0] res,
                                        output logic err);
    longint unsigned sum;
    longint unsigned scaled;
    longint unsigned ceiling;
    ceiling = (64'd1 << RESULT_CELL_WIDTH) - 64'd1;
    res = '0;
    err = 1'b0;
    for (int j = 0; j < MATRIX_WIDTH; j++) begin
        sum = 64'd0;
        for (int i = 0; i < MATRIX_HEIGHT; i++) begin
            sum = sum + longint'(v[i]) * longint'(m[i][j]);
        end
        scaled = sum >> RESULT_SHIFT;
        // Saturated column
        if (scaled > ceiling) begin
            scaled = ceiling;
            err = 1'b1;
        end
        res[j*RESULT_CELL_WIDTH +: RESULT_CELL_WIDTH] = scaled[RESULT_CELL_WIDTH-1:0];
    end
endfunction

`endif

// File: dv/tb_mvm.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mvm
    import mvm_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    // Inputs move this long after the rising edge
    localparam int DRIVE_DLY = 5;
    localparam int LATENCY = N_BEATS + 3;
    localparam int TIMEOUT_EDGES = 40;
    localparam int RANDOM_JOBS = 50;

    logic clk;
    logic reset;
    logic start;
    logic [VECTOR_BITS-1:0] vector;
    logic [MATRIX_BITS-1:0] matrix;
    logic [RESULT_BITS-1:0] result;
    logic valid;
    logic error;

    int error_count = 0;
    int test_count = 0;
    int failed_tests = 0;

    `include "mvm_model.svh"

    mvm dut_i (
        .clk    (clk),
        .reset  (reset),
        .start  (start),
        .vector (vector),
        .matrix (matrix),
        .result (result),
        .valid  (valid),
        .error  (error)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////
    // Stimulus and reporting helpers
    ////////////////////////////////////////

    task automatic random_operands(output vec_arr_t v, output mat_arr_t m,
                                   input int unsigned max_cell);
        for (int i = 0; i < MATRIX_HEIGHT; i++) begin
            v[i] = $urandom_range(max_cell);
            for (int j = 0; j < MATRIX_WIDTH; j++) begin
                m[i][j] = $urandom_range(max_cell);
            end
        end
    endtask

    task automatic apply_operands(input vec_arr_t v, input mat_arr_t m);
        vector = pack_vector(v);
        matrix = pack_matrix(m);
    endtask

    task automatic report_result(input logic [RESULT_BITS-1:0] got,
                                 input logic [RESULT_BITS-1:0] exp);
        $display("[FAIL] result got %h expected %h", got, exp);
        error_count++;
    endtask

    task automatic report_flag(input string sig, input logic got, input logic exp);
        $display("[FAIL] %s got %h expected %h", sig, got, exp);
        error_count++;
    endtask

    task automatic finish_test(input string name, input int errors_before);
        int found;
        found = error_count - errors_before;
        test_count++;
        if (found == 0) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: done with %0d errors", name, found);
        end
    endtask

    // One job from start pulse to valid, called just after a drive point
    task automatic run_job(input vec_arr_t v, input mat_arr_t m);
        logic [RESULT_BITS-1:0] exp_result;
        logic exp_error;
        logic [RESULT_BITS-1:0] prev_result;
        logic prev_error;
        vec_arr_t junk_v;
        mat_arr_t junk_m;
        int edge_no;
        expected_result(v, m, exp_result, exp_error);
        random_operands(junk_v, junk_m, 255);
        // Outputs of the previous job, held until this job's valid
        prev_result = result;
        prev_error = error;
        apply_operands(v, m);
        start = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        start = 1'b0;
        // Ports move on once captured
        apply_operands(junk_v, junk_m);
        // Edge that samples the outputs now on the wires
        edge_no = 1;
        while (valid !== 1'b1 && edge_no <= TIMEOUT_EDGES) begin
            if (result !== prev_result) begin
                report_result(result, prev_result);
            end
            if (error !== prev_error) begin
                report_flag("error", error, prev_error);
            end
            @(posedge clk);
            #DRIVE_DLY;
            edge_no++;
        end
        if (valid !== 1'b1) begin
            $display("valid never arrived within %0d edges of start", TIMEOUT_EDGES);
            error_count++;
        end else begin
            if (edge_no != LATENCY) begin
                $display("[FAIL] valid latency got %h expected %h", edge_no, LATENCY);
                error_count++;
            end
            if (result !== exp_result) begin
                report_result(result, exp_result);
            end
            if (error !== exp_error) begin
                report_flag("error", error, exp_error);
            end
            @(posedge clk);
            #DRIVE_DLY;
            if (valid !== 1'b0) begin
                $display("valid stayed high for more than one cycle");
                error_count++;
            end
        end
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////

    task automatic reset_test();
        int errs;
        errs = error_count;
        for (int c = 0; c < 10; c++) begin
            @(posedge clk);
            #DRIVE_DLY;
            if (valid !== 1'b0) begin
                report_flag("valid", valid, 1'b0);
            end
            if (error !== 1'b0) begin
                report_flag("error", error, 1'b0);
            end
            if (result !== '0) begin
                report_result(result, '0);
            end
        end
        finish_test("reset_state", errs);
    endtask

    task automatic ramp_test();
        vec_arr_t v;
        mat_arr_t m;
        int errs;
        errs = error_count;
        // Vector 1..5, matrix 1..100 row by row
        for (int i = 0; i < MATRIX_HEIGHT; i++) begin
            v[i] = int'(i + 1);
            for (int j = 0; j < MATRIX_WIDTH; j++) begin
                m[i][j] = int'(i * MATRIX_WIDTH + j + 1);
            end
        end
        run_job(v, m);
        finish_test("ramp_pattern", errs);
    endtask

    task automatic random_test(input string name, input int unsigned max_cell);
        vec_arr_t v;
        mat_arr_t m;
        int errs;
        errs = error_count;
        for (int n = 0; n < RANDOM_JOBS; n++) begin
            random_operands(v, m, max_cell);
            run_job(v, m);
        end
        finish_test(name, errs);
    endtask

    // Edge 0 takes the first start, edges 1 and 2 meet a busy sequencer,
    // edge 3 comes right after the last beat and must be accepted
    task automatic busy_start_test();
        vec_arr_t vs [4];
        mat_arr_t ms [4];
        logic [RESULT_BITS-1:0] exp_a;
        logic [RESULT_BITS-1:0] exp_d;
        logic err_a;
        logic err_d;
        int valid_edges [$];
        logic [RESULT_BITS-1:0] valid_results [$];
        logic valid_errors [$];
        int errs;
        errs = error_count;
        for (int k = 0; k < 4; k++) begin
            random_operands(vs[k], ms[k], 255);
        end
        expected_result(vs[0], ms[0], exp_a, err_a);
        expected_result(vs[3], ms[3], exp_d, err_d);
        apply_operands(vs[0], ms[0]);
        start = 1'b1;
        for (int edge_no = 0; edge_no < 14; edge_no++) begin
            @(posedge clk);
            #DRIVE_DLY;
            if (valid === 1'b1) begin
                valid_edges.push_back(edge_no + 1);
                valid_results.push_back(result);
                valid_errors.push_back(error);
            end
            if (edge_no + 1 <= 3) begin
                apply_operands(vs[edge_no + 1], ms[edge_no + 1]);
                start = 1'b1;
            end else begin
                start = 1'b0;
            end
        end
        if (valid_edges.size() != 2) begin
            $display("expected two valid pulses, saw %0d", valid_edges.size());
            error_count++;
        end else begin
            if (valid_edges[0] != LATENCY) begin
                $display("[FAIL] valid latency got %h expected %h", valid_edges[0], LATENCY);
                error_count++;
            end
            if (valid_results[0] !== exp_a) begin
                report_result(valid_results[0], exp_a);
            end
            if (valid_errors[0] !== err_a) begin
                report_flag("error", valid_errors[0], err_a);
            end
            if (valid_edges[1] != 3 + LATENCY) begin
                $display("[FAIL] valid edge got %h expected %h", valid_edges[1], 3 + LATENCY);
                error_count++;
            end
            if (valid_results[1] !== exp_d) begin
                report_result(valid_results[1], exp_d);
            end
            if (valid_errors[1] !== err_d) begin
                report_flag("error", valid_errors[1], err_d);
            end
        end
        finish_test("start_while_busy", errs);
    endtask

    task automatic hold_test();
        vec_arr_t v;
        mat_arr_t m;
        logic [RESULT_BITS-1:0] held_result;
        logic held_error;
        int errs;
        errs = error_count;
        // Saturating job first, then a clean one
        for (int round = 0; round < 2; round++) begin
            random_operands(v, m, (round == 0) ? 255 : 31);
            run_job(v, m);
            held_result = result;
            held_error = error;
            for (int c = 0; c < 8; c++) begin
                @(posedge clk);
                #DRIVE_DLY;
                if (valid !== 1'b0) begin
                    $display("valid pulsed with no job running");
                    error_count++;
                end
                if (result !== held_result) begin
                    report_result(result, held_result);
                end
                if (error !== held_error) begin
                    report_flag("error", error, held_error);
                end
            end
        end
        finish_test("hold_between_jobs", errs);
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        reset = 1'b1;
        start = 1'b0;
        vector = '0;
        matrix = '0;
        void'($urandom(32'ha063b75c));
        repeat (4) @(posedge clk);
        #DRIVE_DLY;
        reset = 1'b0;

        reset_test();
        ramp_test();
        random_test("random_no_saturation", 31);
        random_test("random_saturation", 255);
        busy_start_test();
        hold_test();

        $display("tests: %0d, failed tests: %0d, errors: %0d",
                 test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+dv
verilog/mvm_pkg.sv
verilog/mvm_beat_if.sv
verilog/mvm_row_sequencer.sv
verilog/vector_mac.sv
verilog/mvm_accumulator.sv
verilog/mvm_result_formatter.sv
verilog/mvm.sv
dv/tb_mvm.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the mvm testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f vlog.f --top-module tb_mvm -o tb_mvm

# Keep the simulator output for the pass check below
./obj_dir/tb_mvm > sim.log 2>&1 || true
cat sim.log

if grep -q 'All tests passed!' sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
